//--- rej_sampler.f
hw/rej_pkg.sv
hw/rej_bounded_filter.sv
hw/abr_sample_buffer.sv
hw/rej_bounded_ctrl.sv
hw/rej_apb_slave.sv
hw/rej_sampler_top.sv
testbench/rej_sampler_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the sampler testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
  --top-module rej_sampler_tb -f rej_sampler.f -o rej_sampler_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/rej_sampler_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^TESTBENCH PASSED$"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- testbench/rej_sampler_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rej_sampler_tb
  import rej_pkg::*;
();

  localparam int          NUM_TESTS   = 6;
  localparam int          STALL_LIMIT = 100;
  localparam int          GROUP       = 4;
  localparam logic [7:0]  REG_COEFF3  = 8'h18;
  localparam logic [7:0]  REG_BAD     = 8'h1C;
  localparam logic [31:0] LFSR_SEED   = 32'hc7a9e58d;
  // Six tests at 2000 cycles of 40 ns each
  localparam int          WATCHDOG_NS = NUM_TESTS * 2000 * 40;

  logic        clk;
  logic        rst_i;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic [31:0] lfsr;
  logic        wr_done;
  int          errors;
  int          pass_count;
  int          fail_count;
  // Coefficients the DUT should be holding with the oldest first
  int unsigned exp_q[$];

  rej_sampler_top rej_sampler_top_inst (
    .clk       (clk),
    .rst_i     (rst_i),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp)
  );

  always #20 clk = ~clk;

  // Galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit of the word
  task automatic next_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w    = {w[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // STATUS holds count in 4:0, hold in bit 5 and out_valid in bit 6
  function automatic logic [31:0] status_word(input int count);
    logic [31:0] w;
    w    = 32'(count) & 32'h1f;
    w[5] = count > 12 - 8;
    w[6] = count >= GROUP;
    return w;
  endfunction

  // Coefficient is (2 - (a mod 5)) mod q
  function automatic int unsigned coeff_of(input int unsigned a);
    int q;
    q = int'(DILITHIUM_Q);
    return int'((q + 2 - int'(a % 5)) % q);
  endfunction

  // Nibbles from bits 3:0 upward with value 15 dropped
  task automatic model_push(input logic [31:0] w);
    logic [3:0] nib;
    for (int i = 0; i < 8; i++) begin
      nib = w[4*i +: 4];
      if (nib != 4'hF) begin
        exp_q.push_back(coeff_of(int'(nib)));
      end
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("ERR t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
    errors++;
  endtask

  // Setup cycle then access cycles until pready is seen at a falling edge
  task automatic apb_transfer(input logic wr, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int   waits;
    logic done;
    waits = 0;
    done  = 1'b0;
    rdata = '0;
    err   = 1'b0;
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    while (!done && waits < STALL_LIMIT) begin
      @(negedge clk);
      if (apb_rsp.pready) begin
        done  = 1'b1;
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
      end else begin
        waits++;
      end
    end
    if (!done) begin
      $display("APB transfer at 0x%0h stalled for %0d cycles without pready",
               addr, STALL_LIMIT);
      errors++;
    end
    // Transfer ends at this edge
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused_rd;
    logic        err;
    apb_transfer(1'b1, addr, data, unused_rd, err);
    if (err) begin
      $display("APB write to 0x%0h answered with an unexpected slave error", addr);
      errors++;
    end
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_transfer(1'b0, addr, '0, data, err);
    if (err) begin
      $display("APB read of 0x%0h answered with an unexpected slave error", addr);
      errors++;
    end
  endtask

  // STATUS against the fill level the model predicts
  task automatic check_status(output logic [31:0] rd);
    apb_read(REG_STATUS, rd);
    if (rd != status_word(exp_q.size())) begin
      report_mismatch("STATUS", status_word(exp_q.size()), rd);
    end
  endtask

  // COEFF3 comes last since reading it pops the group
  task automatic read_group();
    logic [31:0]  rd;
    int unsigned  exp;
    for (int k = 0; k < GROUP; k++) begin
      apb_read(REG_COEFF0 + 8'(4 * k), rd);
      if (exp_q.size() == 0) begin
        $display("Coefficient %0d read but the model expects no sample", k);
        errors++;
      end else begin
        exp = exp_q.pop_front();
        if (rd != 32'(exp)) begin
          report_mismatch($sformatf("COEFF%0d", k), 32'(exp), rd);
        end
      end
    end
  endtask

  // Pop while a full group waits
  // Count stays below 12 so at most two pops are needed
  task automatic drain_groups();
    logic [31:0] rd;
    int          guard;
    guard = 0;
    check_status(rd);
    while (rd[4:0] >= 5'(GROUP) && guard < 4) begin
      read_group();
      check_status(rd);
      guard++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      pass_count++;
      $display("test %s done, no errors", name);
    end else begin
      fail_count++;
      $display("test %s done, %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic test_reset_state();
    int          e0;
    logic [31:0] rd;
    e0 = errors;
    check_status(rd);
    // With nothing buffered COEFF3 reads zero and must not pop
    apb_read(REG_COEFF3, rd);
    if (rd != 32'd0) begin
      report_mismatch("COEFF3", 32'd0, rd);
    end
    check_status(rd);
    finish_test("reset_state", e0);
  endtask

  task automatic test_filter_map();
    int          e0;
    logic [31:0] rd;
    e0 = errors;
    apb_write(REG_DATA_IN, 32'h43210765);
    model_push(32'h43210765);
    check_status(rd);
    read_group();
    read_group();
    check_status(rd);
    finish_test("filter_map", e0);
  endtask

  task automatic test_rejection();
    int          e0;
    logic [31:0] rd;
    e0 = errors;
    apb_write(REG_DATA_IN, 32'hFFFFFFFF);
    model_push(32'hFFFFFFFF);
    check_status(rd);
    apb_write(REG_DATA_IN, 32'hFFFFFFF4);
    model_push(32'hFFFFFFF4);
    check_status(rd);
    // Three more to fill a group behind the lone 4
    apb_write(REG_DATA_IN, 32'hFFFFF012);
    model_push(32'hFFFFF012);
    check_status(rd);
    apb_read(REG_COEFF0, rd);
    if (rd != 32'(DILITHIUM_Q - 24'd2)) begin
      report_mismatch("COEFF0", 32'(DILITHIUM_Q - 24'd2), rd);
    end
    read_group();
    check_status(rd);
    finish_test("rejection", e0);
  endtask

  task automatic test_back_pressure();
    int          e0;
    int          waits;
    logic [31:0] rd;
    e0 = errors;
    apb_write(REG_DATA_IN, 32'h43210765);
    model_push(32'h43210765);
    check_status(rd);
    wr_done = 1'b0;
    fork
      begin
        apb_write(REG_DATA_IN, 32'h01234567);
        wr_done = 1'b1;
      end
    join_none
    // Count 8 keeps hold high and the write sits in wait states
    repeat (20) begin
      @(negedge clk);
      if (wr_done || apb_rsp.pready) begin
        $display("DATA_IN write completed while hold was high");
        errors++;
      end
    end
    // Only a reset can drain the buffer while the stalled write owns the bus
    @(posedge clk);
    rst_i <= 1'b1;
    @(posedge clk);
    rst_i <= 1'b0;
    exp_q.delete();
    waits = 0;
    while (!wr_done && waits < STALL_LIMIT) begin
      @(posedge clk);
      waits++;
    end
    if (!wr_done) begin
      $display("Stalled DATA_IN write never completed after hold dropped");
      errors++;
    end
    model_push(32'h01234567);
    check_status(rd);
    read_group();
    read_group();
    check_status(rd);
    finish_test("back_pressure", e0);
  endtask

  task automatic test_random_stream();
    int          e0;
    logic [31:0] w;
    e0 = errors;
    for (int n = 0; n < 40; n++) begin
      drain_groups();
      next_word(w);
      apb_write(REG_DATA_IN, w);
      model_push(w);
    end
    drain_groups();
    // A word of zeros pushes the last random samples out in full groups
    apb_write(REG_DATA_IN, 32'h0);
    model_push(32'h0);
    drain_groups();
    finish_test("random_stream", e0);
  endtask

  task automatic test_zeroize_addr();
    int          e0;
    logic [31:0] rd;
    logic        err;
    e0 = errors;
    apb_write(REG_DATA_IN, 32'h3333FFFF);
    model_push(32'h3333FFFF);
    check_status(rd);
    apb_write(REG_CTRL, 32'h1);
    exp_q.delete();
    check_status(rd);
    // Past the last coefficient register
    apb_transfer(1'b0, REG_BAD, '0, rd, err);
    if (err != 1'b1) begin
      report_mismatch("pslverr", 32'd1, 32'(err));
    end
    finish_test("zeroize_addr", e0);
  endtask

  initial begin
    clk        = 1'b0;
    rst_i      = 1'b1;
    apb_req    = '0;
    lfsr       = LFSR_SEED;
    wr_done    = 1'b0;
    errors     = 0;
    pass_count = 0;
    fail_count = 0;
    repeat (3) @(posedge clk);
    rst_i <= 1'b0;
    test_reset_state();
    test_filter_map();
    test_rejection();
    test_back_pressure();
    test_random_stream();
    test_zeroize_addr();
    $display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/rej_sampler_top.sv
`timescale 1ns/1ps
`default_nettype none

module rej_sampler_top
  import rej_pkg::*;
#(
  parameter int REJ_NUM_SAMPLERS = 8,
  parameter int REJ_VLD_SAMPLES  = 4,
  parameter int BUFFER_DEPTH     = 12
) (
  input  logic     clk,
  input  logic     rst_i,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o
);

  // Link between register block and sampler chain
  logic                                          word_valid;
  logic [REJ_NUM_SAMPLERS-1:0][REJ_SAMPLE_W-1:0] word;
  logic                                          data_hold;
  logic                                          pop;
  logic                                          zeroize;
  logic [REJ_VLD_SAMPLES-1:0][REJ_COEFF_W-1:0]   coeffs;
  rej_status_t                                   status;

  // Host registers
  rej_apb_slave #(
    .REJ_NUM_SAMPLERS(REJ_NUM_SAMPLERS),
    .REJ_VLD_SAMPLES (REJ_VLD_SAMPLES)
  ) rej_apb_slave_inst (
    .clk          (clk),
    .rst_i        (rst_i),
    .apb_req_i    (apb_req_i),
    .apb_rsp_o    (apb_rsp_o),
    .word_valid_o (word_valid),
    .word_o       (word),
    .hold_i       (data_hold),
    .pop_o        (pop),
    .coeff_i      (coeffs),
    .status_i     (status),
    .zeroize_o    (zeroize)
  );

  // Filter, buffer and coefficient mapping
  // Group valid reaches the slave inside the status struct
  rej_bounded_ctrl #(
    .REJ_NUM_SAMPLERS(REJ_NUM_SAMPLERS),
    .REJ_VLD_SAMPLES (REJ_VLD_SAMPLES),
    .BUFFER_DEPTH    (BUFFER_DEPTH)
  ) rej_bounded_ctrl_inst (
    .clk          (clk),
    .rst_i        (rst_i),
    .zeroize_i    (zeroize),
    .data_valid_i (word_valid),
    .data_hold_o  (data_hold),
    .data_i       (word),
    .data_ready_i (pop),
    .data_valid_o (),
    .data_o       (coeffs),
    .status_o     (status)
  );

endmodule

`default_nettype wire

//--- hw/rej_apb_slave.sv
`timescale 1ns/1ps
`default_nettype none

module rej_apb_slave
  import rej_pkg::*;
#(
  parameter int REJ_NUM_SAMPLERS = 8,
  parameter int REJ_VLD_SAMPLES  = 4
) (
  input  logic                                          clk,
  input  logic                                          rst_i,
  input  apb_req_t                                      apb_req_i,
  output apb_rsp_t                                      apb_rsp_o,
  output logic                                          word_valid_o,
  output logic [REJ_NUM_SAMPLERS-1:0][REJ_SAMPLE_W-1:0] word_o,
  input  logic                                          hold_i,
  output logic                                          pop_o,
  input  logic [REJ_VLD_SAMPLES-1:0][REJ_COEFF_W-1:0]   coeff_i,
  input  rej_status_t                                   status_i,
  output logic                                          zeroize_o
);

  // Reading the last coefficient word releases the group
  localparam logic [APB_ADDR_W-1:0] REG_LAST =
    REG_COEFF0 + APB_ADDR_W'(4 * (REJ_VLD_SAMPLES - 1));

  logic                  access;
  logic                  wr_access;
  logic                  rd_access;
  logic                  addr_err;
  logic                  sel_data_in;
  logic                  stall;
  logic                  zeroize_q;
  logic [APB_DATA_W-1:0] rd_data;

  // Access phase of the current transfer
  assign access    = apb_req_i.psel && apb_req_i.penable;
  assign wr_access = access && apb_req_i.pwrite;
  assign rd_access = access && !apb_req_i.pwrite;

  assign addr_err    = apb_req_i.paddr > REG_LAST;
  assign sel_data_in = apb_req_i.paddr == REG_DATA_IN;

  // DATA_IN write waits out the hold
  assign stall        = wr_access && sel_data_in && hold_i;
  assign word_valid_o = wr_access && sel_data_in && !hold_i;
  assign word_o       = apb_req_i.pwdata[REJ_NUM_SAMPLERS*REJ_SAMPLE_W-1:0];

  // Pop on the completing read of the last coefficient
  assign pop_o = rd_access && (apb_req_i.paddr == REG_LAST) && status_i.out_valid;

  // Read mux, coefficients read as zero until a group is ready
  always_comb begin
    rd_data = '0;
    if (rd_access && !addr_err) begin
      if (apb_req_i.paddr == REG_STATUS) begin
        rd_data = APB_DATA_W'(status_i);
      end
      for (int k = 0; k < REJ_VLD_SAMPLES; k++) begin
        if (status_i.out_valid &&
            apb_req_i.paddr == REG_COEFF0 + APB_ADDR_W'(4 * k)) begin
          rd_data = APB_DATA_W'(coeff_i[k]);
        end
      end
    end
  end

  // CTRL bit 0 is self clearing, one cycle pulse after the write
  always_ff @(posedge clk) begin
    if (rst_i) begin
      zeroize_q <= 1'b0;
    end else begin
      zeroize_q <= wr_access && (apb_req_i.paddr == REG_CTRL) && apb_req_i.pwdata[0];
    end
  end

  assign zeroize_o = zeroize_q;

  always_comb begin
    apb_rsp_o.prdata  = rd_data;
    apb_rsp_o.pready  = access && !stall;
    apb_rsp_o.pslverr = access && addr_err;
  end

  // Ready only in an access phase that a setup cycle led into
  a_ready_in_access: assert property (@(posedge clk) disable iff (rst_i)
    apb_rsp_o.pready |-> access && $past(apb_req_i.psel))
  else $error("pready outside an APB access phase");

  // Master keeps a stalled DATA_IN write on the bus
  a_stall_held: assert property (@(posedge clk) disable iff (rst_i)
    stall |=> wr_access && sel_data_in)
  else $error("stalled DATA_IN write dropped by master");

endmodule

`default_nettype wire

//--- hw/rej_bounded_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rej_bounded_ctrl
  import rej_pkg::*;
#(
  parameter int REJ_NUM_SAMPLERS = 8,
  parameter int REJ_VLD_SAMPLES  = 4,
  parameter int BUFFER_DEPTH     = 12
) (
  input  logic                                          clk,
  input  logic                                          rst_i,
  input  logic                                          zeroize_i,
  input  logic                                          data_valid_i,
  output logic                                          data_hold_o,
  input  logic [REJ_NUM_SAMPLERS-1:0][REJ_SAMPLE_W-1:0] data_i,
  input  logic                                          data_ready_i,
  output logic                                          data_valid_o,
  output logic [REJ_VLD_SAMPLES-1:0][REJ_COEFF_W-1:0]   data_o,
  output rej_status_t                                   status_o
);

  logic [REJ_NUM_SAMPLERS-1:0]                   lane_valid;
  logic [REJ_NUM_SAMPLERS-1:0][REJ_BUFFER_W-1:0] lane_residue;
  logic [REJ_VLD_SAMPLES-1:0][REJ_BUFFER_W-1:0]  group_residue;
  logic                                          group_valid;
  logic                                          buffer_full;
  logic [REJ_COUNT_W-1:0]                        buffer_count;

  // Reject and reduce every lane of the word at once
  rej_bounded_filter #(
    .REJ_NUM_SAMPLERS(REJ_NUM_SAMPLERS)
  ) rej_bounded_filter_inst (
    .valid_i (data_valid_i),
    .data_i  (data_i),
    .valid_o (lane_valid),
    .data_o  (lane_residue)
  );

  // Compact accepted residues and hand out groups
  abr_sample_buffer #(
    .NUM_WR (REJ_NUM_SAMPLERS),
    .NUM_RD (REJ_VLD_SAMPLES),
    .DEPTH  (BUFFER_DEPTH)
  ) abr_sample_buffer_inst (
    .clk           (clk),
    .rst_i         (rst_i),
    .zeroize_i     (zeroize_i),
    .data_valid_i  (lane_valid),
    .data_i        (lane_residue),
    .data_ready_i  (data_ready_i),
    .buffer_full_o (buffer_full),
    .data_valid_o  (group_valid),
    .count_o       (buffer_count),
    .data_o        (group_residue)
  );

  // Back-pressure straight from the registered fill level
  assign data_hold_o  = buffer_full;
  assign data_valid_o = group_valid;

  // Coefficient is 2 - r taken mod q
  always_comb begin
    for (int k = 0; k < REJ_VLD_SAMPLES; k++) begin
      unique case (group_residue[k])
        3'd0:    data_o[k] = REJ_COEFF_W'(2);
        3'd1:    data_o[k] = REJ_COEFF_W'(1);
        3'd2:    data_o[k] = '0;
        3'd3:    data_o[k] = DILITHIUM_Q - REJ_COEFF_W'(1);
        3'd4:    data_o[k] = DILITHIUM_Q - REJ_COEFF_W'(2);
        default: data_o[k] = '0;
      endcase
    end
  end

  assign status_o.out_valid = group_valid;
  assign status_o.hold      = buffer_full;
  assign status_o.count     = buffer_count;

endmodule

`default_nettype wire

//--- hw/abr_sample_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module abr_sample_buffer
  import rej_pkg::*;
#(
  parameter int NUM_WR = 8,
  parameter int NUM_RD = 4,
  parameter int DEPTH  = 12
) (
  input  logic                                clk,
  input  logic                                rst_i,
  input  logic                                zeroize_i,
  input  logic [NUM_WR-1:0]                   data_valid_i,
  input  logic [NUM_WR-1:0][REJ_BUFFER_W-1:0] data_i,
  input  logic                                data_ready_i,
  output logic                                buffer_full_o,
  output logic                                data_valid_o,
  output logic [REJ_COUNT_W-1:0]              count_o,
  output logic [NUM_RD-1:0][REJ_BUFFER_W-1:0] data_o
);

  // Entry 0 is the oldest sample
  logic [DEPTH-1:0][REJ_BUFFER_W-1:0] buf_q;
  logic [DEPTH-1:0][REJ_BUFFER_W-1:0] buf_d;
  logic [DEPTH-1:0][REJ_BUFFER_W-1:0] shifted;
  logic [REJ_COUNT_W-1:0]             count_q;
  logic [REJ_COUNT_W-1:0]             wr_ptr;

  // Next contents, pop first then pack the new lanes behind
  always_comb begin
    shifted = buf_q;
    wr_ptr  = count_q;
    if (data_ready_i) begin
      // Drop the oldest group and move the rest to the front
      shifted = '0;
      for (int j = 0; j < DEPTH - NUM_RD; j++) begin
        shifted[j] = buf_q[j+NUM_RD];
      end
      wr_ptr = count_q - REJ_COUNT_W'(NUM_RD);
    end
    buf_d = shifted;
    // Running pointer acts as the prefix count of valid lanes
    for (int lane = 0; lane < NUM_WR; lane++) begin
      if (data_valid_i[lane]) begin
        for (int j = 0; j < DEPTH; j++) begin
          if (wr_ptr == REJ_COUNT_W'(j)) begin
            buf_d[j] = data_i[lane];
          end
        end
        wr_ptr = wr_ptr + 1'b1;
      end
    end
  end

  // Fill level
  always_ff @(posedge clk) begin
    if (rst_i || zeroize_i) begin
      count_q <= '0;
    end else begin
      count_q <= wr_ptr;
    end
  end

  // Sample storage, wiped on zeroize
  always_ff @(posedge clk) begin
    if (zeroize_i) begin
      buf_q <= '0;
    end else begin
      buf_q <= buf_d;
    end
  end

  // Full means a whole word of lanes might not fit
  assign buffer_full_o = count_q > REJ_COUNT_W'(DEPTH - NUM_WR);
  assign data_valid_o  = count_q >= REJ_COUNT_W'(NUM_RD);
  assign count_o       = count_q;
  assign data_o        = buf_q[NUM_RD-1:0];

  // Overflow guard
  a_count_bound: assert property (@(posedge clk) disable iff (rst_i)
    count_q <= REJ_COUNT_W'(DEPTH))
  else $error("sample buffer count %0d above depth", count_q);

  // Upstream must honor hold
  a_no_push_full: assert property (@(posedge clk) disable iff (rst_i)
    buffer_full_o |-> !(|data_valid_i))
  else $error("sample buffer push while full");

  // Pop only when a full group is waiting
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst_i)
    data_ready_i |-> data_valid_o)
  else $error("sample buffer pop without a group");

endmodule

`default_nettype wire

//--- hw/rej_bounded_filter.sv
`timescale 1ns/1ps
`default_nettype none

module rej_bounded_filter
  import rej_pkg::*;
#(
  parameter int REJ_NUM_SAMPLERS = 8
) (
  input  logic                                          valid_i,
  input  logic [REJ_NUM_SAMPLERS-1:0][REJ_SAMPLE_W-1:0] data_i,
  output logic [REJ_NUM_SAMPLERS-1:0]                   valid_o,
  output logic [REJ_NUM_SAMPLERS-1:0][REJ_BUFFER_W-1:0] data_o
);

  // Residue of each accepted candidate modulo 5
  localparam logic [REJ_BUFFER_W-1:0] MOD5_LUT [15] = '{
    3'd0, 3'd1, 3'd2, 3'd3, 3'd4,
    3'd0, 3'd1, 3'd2, 3'd3, 3'd4,
    3'd0, 3'd1, 3'd2, 3'd3, 3'd4
  };

  // Lanes are independent and hold no state
  always_comb begin
    for (int lane = 0; lane < REJ_NUM_SAMPLERS; lane++) begin
      // Rejected lanes drop their valid bit
      valid_o[lane] = valid_i && (data_i[lane] != REJ_VALUE);
      // Table covers 0 to 14 only
      if (data_i[lane] != REJ_VALUE) begin
        data_o[lane] = MOD5_LUT[data_i[lane]];
      end else begin
        data_o[lane] = '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/rej_pkg.sv
`default_nettype none

package rej_pkg;

  // Coefficient ring for ML-DSA
  localparam int unsigned REJ_COEFF_W = 24;
  localparam logic [REJ_COEFF_W-1:0] DILITHIUM_Q = 24'd8380417;

  // Candidate nibble and reduced residue widths
  localparam int unsigned REJ_SAMPLE_W = 4;
  localparam int unsigned REJ_BUFFER_W = 3;
  // Wide enough for a buffer depth up to 31
  localparam int unsigned REJ_COUNT_W = 5;

  // Candidate that never produces a sample for eta 2
  localparam logic [REJ_SAMPLE_W-1:0] REJ_VALUE = 4'd15;

  localparam int unsigned APB_ADDR_W = 8;
  localparam int unsigned APB_DATA_W = 32;

  // Register map, coefficient words follow COEFF0 at 4 byte steps
  localparam logic [APB_ADDR_W-1:0] REG_CTRL    = 8'h00;
  localparam logic [APB_ADDR_W-1:0] REG_STATUS  = 8'h04;
  localparam logic [APB_ADDR_W-1:0] REG_DATA_IN = 8'h08;
  localparam logic [APB_ADDR_W-1:0] REG_COEFF0  = 8'h0C;

  // Master side of the APB link
  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  // Slave response
  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

  // Sampler state seen by the host, out_valid lands in STATUS bit 6
  typedef struct packed {
    logic                   out_valid;
    logic                   hold;
    logic [REJ_COUNT_W-1:0] count;
  } rej_status_t;

endpackage

`default_nettype wire
